// ==== rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath width
`define RV_XLEN 64

`define RV_NREG 32

// data memory depth in 64-bit words
`define RV_DMEM_WORDS 512

`define RV_RESET_PC 64'h0

`endif

// ==== rv_pkg.sv ====
package rv_pkg;

  // instruction word and register index widths
  localparam int unsigned INST_W    = 32;
  localparam int unsigned REG_IDX_W = 5;

  // executed operations, one per supported instruction
  typedef enum logic [3:0] {
    op_addi,
    op_add,
    op_sub,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_bne,
    op_lw,
    op_ld,
    op_sd,
    op_addiw,
    op_addw,
    op_ebreak,
    op_illegal
  } op_e;

  // alu_ne returns 1 on mismatch, used by bne
  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_ne
  } alu_mode_e;

endpackage

// ==== rv_decode_if.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

interface rv_decode_if;

  rv_pkg::op_e                   op;
  logic [rv_pkg::REG_IDX_W-1:0]  rd;
  logic [rv_pkg::REG_IDX_W-1:0]  rs1;
  logic [rv_pkg::REG_IDX_W-1:0]  rs2;
  // sign-extended per instruction format
  logic [`RV_XLEN-1:0]           imm;

  modport idu (
    output op, rd, rs1, rs2, imm
  );

  modport exu (
    input op, rd, rs1, rs2, imm
  );

endinterface

// ==== rv_alu.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_alu (
  input  rv_pkg::alu_mode_e    mode,
  input  logic [`RV_XLEN-1:0]  a,
  input  logic [`RV_XLEN-1:0]  b,
  output logic [`RV_XLEN-1:0]  result
);

  always_comb begin
    case (mode)
      rv_pkg::alu_add: result = a + b;
      rv_pkg::alu_sub: result = a - b;
      // branch compare, nonzero means taken
      rv_pkg::alu_ne:  result = {{(`RV_XLEN-1){1'b0}}, a != b};
      default:         result = a + b;
    endcase
  end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_regfile (
  input  logic                         clk,
  input  logic                         arst_n,
  input  logic                         we,
  input  logic [rv_pkg::REG_IDX_W-1:0] waddr,
  input  logic [`RV_XLEN-1:0]          wdata,
  input  logic [rv_pkg::REG_IDX_W-1:0] raddr1,
  input  logic [rv_pkg::REG_IDX_W-1:0] raddr2,
  output logic [`RV_XLEN-1:0]          rdata1,
  output logic [`RV_XLEN-1:0]          rdata2
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NREG-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < `RV_NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

  // the execute unit filters x0 writes before they get here
  no_x0_write_a: assert property (@(posedge clk) disable iff (!arst_n)
    we |-> waddr != '0)
    else $error("rv_regfile: write issued to x0");

endmodule

// ==== rv_dmem.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_dmem (
  input  logic                   clk,
  input  logic                   we,
  input  logic [`RV_XLEN-1:0]    addr,
  input  logic [`RV_XLEN-1:0]    wdata,
  input  logic [`RV_XLEN/8-1:0]  wmask,
  output logic [`RV_XLEN-1:0]    rdata
);

  localparam int unsigned IDX_W = $clog2(`RV_DMEM_WORDS);
  localparam int unsigned OFS_W = $clog2(`RV_XLEN/8);

  logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
  logic [IDX_W-1:0]    idx;

  // word index sits above the byte offset
  assign idx   = addr[IDX_W+OFS_W-1:OFS_W];
  assign rdata = mem[idx];

  // power-on contents
  initial begin
    for (int i = 0; i < `RV_DMEM_WORDS; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < `RV_XLEN/8; i++) begin
        if (wmask[i]) begin
          mem[idx][i*8 +: 8] <= wdata[i*8 +: 8];
        end
      end
    end
  end

  // only sd reaches the memory
  wr_aligned_a: assert property (@(posedge clk)
    we |-> addr[OFS_W-1:0] == '0)
    else $error("rv_dmem: unaligned write to %h", addr);

endmodule

// ==== rv_idu.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_idu (
  input  logic [rv_pkg::INST_W-1:0] inst,
  rv_decode_if.idu                  dec
);

  // major opcodes
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_OP_32  = 7'b0111011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [rv_pkg::INST_W-1:0] INST_EBREAK = 32'h0010_0073;

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  logic [6:0]          funct7;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_b;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  rv_pkg::op_e         op;

  assign opcode = inst[6:0];
  assign funct3 = inst[14:12];
  assign funct7 = inst[31:25];

  assign imm_i = {{(`RV_XLEN-12){inst[31]}}, inst[31:20]};
  assign imm_s = {{(`RV_XLEN-12){inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{(`RV_XLEN-13){inst[31]}}, inst[31], inst[7], inst[30:25],
                  inst[11:8], 1'b0};
  assign imm_u = {{(`RV_XLEN-32){inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{(`RV_XLEN-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  always_comb begin
    op = rv_pkg::op_illegal;
    case (opcode)
      OPC_OP_IMM: if (funct3 == 3'b000) op = rv_pkg::op_addi;
      OPC_OP: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op = rv_pkg::op_add;
        if (funct3 == 3'b000 && funct7 == 7'b0100000) op = rv_pkg::op_sub;
      end
      OPC_LUI:    op = rv_pkg::op_lui;
      OPC_AUIPC:  op = rv_pkg::op_auipc;
      OPC_JAL:    op = rv_pkg::op_jal;
      OPC_JALR:   if (funct3 == 3'b000) op = rv_pkg::op_jalr;
      OPC_BRANCH: if (funct3 == 3'b001) op = rv_pkg::op_bne;
      OPC_LOAD: begin
        if (funct3 == 3'b010) op = rv_pkg::op_lw;
        if (funct3 == 3'b011) op = rv_pkg::op_ld;
      end
      OPC_STORE:  if (funct3 == 3'b011) op = rv_pkg::op_sd;
      OPC_IMM_32: if (funct3 == 3'b000) op = rv_pkg::op_addiw;
      OPC_OP_32: begin
        if (funct3 == 3'b000 && funct7 == 7'b0000000) op = rv_pkg::op_addw;
      end
      default: begin
        if (inst == INST_EBREAK) op = rv_pkg::op_ebreak;
      end
    endcase
  end

  // immediate format follows the matched op
  always_comb begin
    case (op)
      rv_pkg::op_lui,
      rv_pkg::op_auipc: dec.imm = imm_u;
      rv_pkg::op_jal:   dec.imm = imm_j;
      rv_pkg::op_bne:   dec.imm = imm_b;
      rv_pkg::op_sd:    dec.imm = imm_s;
      default:          dec.imm = imm_i;
    endcase
  end

  assign dec.op  = op;
  assign dec.rd  = inst[11:7];
  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];

endmodule

// ==== rv_exu.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_exu (
  input  logic                     clk,
  input  logic                     arst_n,
  input  logic                     commit_en,
  rv_decode_if.exu                 dec,
  input  logic [`RV_XLEN-1:0]      pc,
  output logic                     wen,
  output logic [`RV_XLEN-1:0]      wdata,
  output logic [`RV_XLEN-1:0]      dnpc,
  output logic                     ebreak,
  output logic [`RV_XLEN-1:0]      a0,
  output logic [`RV_XLEN-1:0]      dmem_addr,
  output logic [`RV_XLEN-1:0]      dmem_wdata,
  output logic [`RV_XLEN/8-1:0]    dmem_wmask,
  output logic                     dmem_we,
  input  logic [`RV_XLEN-1:0]      dmem_rdata
);

  localparam logic [rv_pkg::REG_IDX_W-1:0] A0_IDX = 10;

  logic [rv_pkg::REG_IDX_W-1:0] raddr1;
  logic [`RV_XLEN-1:0]          src1;
  logic [`RV_XLEN-1:0]          src2;
  logic [`RV_XLEN-1:0]          op_a;
  logic [`RV_XLEN-1:0]          op_b;
  logic [`RV_XLEN-1:0]          alu_res;
  logic [`RV_XLEN-1:0]          snpc;
  logic [31:0]                  lw_half;
  rv_pkg::alu_mode_e            alu_mode;
  logic                         wen_raw;

  // ebreak borrows read port 1 to fetch a0 for the halt code
  assign raddr1 = (dec.op == rv_pkg::op_ebreak) ? A0_IDX : dec.rs1;
  assign a0     = src1;

  rv_regfile u_regfile (
    .clk    (clk),
    .arst_n (arst_n),
    .we     (wen),
    .waddr  (dec.rd),
    .wdata  (wdata),
    .raddr1 (raddr1),
    .raddr2 (dec.rs2),
    .rdata1 (src1),
    .rdata2 (src2)
  );

  // operand and mode select
  always_comb begin
    op_a     = src1;
    op_b     = dec.imm;
    alu_mode = rv_pkg::alu_add;
    case (dec.op)
      rv_pkg::op_auipc,
      rv_pkg::op_jal: begin
        op_a = pc;
      end
      rv_pkg::op_add,
      rv_pkg::op_addw: begin
        op_b = src2;
      end
      rv_pkg::op_sub: begin
        op_b     = src2;
        alu_mode = rv_pkg::alu_sub;
      end
      rv_pkg::op_bne: begin
        op_b     = src2;
        alu_mode = rv_pkg::alu_ne;
      end
      default: begin
      end
    endcase
  end

  rv_alu u_alu (
    .mode   (alu_mode),
    .a      (op_a),
    .b      (op_b),
    .result (alu_res)
  );

  assign snpc = pc + `RV_XLEN'd4;

  // lw takes one half of the doubleword by address bit 2
  assign lw_half = dmem_addr[2] ? dmem_rdata[`RV_XLEN-1:32] : dmem_rdata[31:0];

  always_comb begin
    wen_raw = 1'b1;
    wdata   = alu_res;
    case (dec.op)
      rv_pkg::op_addi,
      rv_pkg::op_add,
      rv_pkg::op_sub,
      rv_pkg::op_auipc: wdata = alu_res;
      rv_pkg::op_addiw,
      rv_pkg::op_addw:  wdata = {{(`RV_XLEN-32){alu_res[31]}}, alu_res[31:0]};
      rv_pkg::op_lui:   wdata = dec.imm;
      rv_pkg::op_jal,
      rv_pkg::op_jalr:  wdata = snpc;
      rv_pkg::op_lw:    wdata = {{(`RV_XLEN-32){lw_half[31]}}, lw_half};
      rv_pkg::op_ld:    wdata = dmem_rdata;
      default:          wen_raw = 1'b0;
    endcase
  end

  // writes to x0 are dropped here
  assign wen = wen_raw && commit_en && (dec.rd != '0);

  always_comb begin
    case (dec.op)
      rv_pkg::op_jal:  dnpc = alu_res;
      rv_pkg::op_jalr: dnpc = {alu_res[`RV_XLEN-1:1], 1'b0};
      rv_pkg::op_bne:  dnpc = (alu_res != '0) ? pc + dec.imm : snpc;
      default:         dnpc = snpc;
    endcase
  end

  assign dmem_addr  = alu_res;
  assign dmem_wdata = src2;
  assign dmem_wmask = (dec.op == rv_pkg::op_sd) ? '1 : '0;
  assign dmem_we    = (dec.op == rv_pkg::op_sd) && commit_en;

  assign ebreak = (dec.op == rv_pkg::op_ebreak) && commit_en;

  // pc from the top level must stay word aligned
  dnpc_aligned_a: assert property (@(posedge clk) disable iff (!arst_n)
    commit_en |-> dnpc[1:0] == 2'b00)
    else $error("rv_exu: misaligned next pc %h", dnpc);

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps
`include "rv_defines.svh"

module rv_core (
  input  logic                          clk,
  input  logic                          arst_n,
  input  logic [rv_pkg::INST_W-1:0]     inst,
  input  logic                          inst_valid,
  output logic [`RV_XLEN-1:0]           pc,
  output logic                          commit_valid,
  output logic                          commit_wen,
  output logic [rv_pkg::REG_IDX_W-1:0]  commit_rd,
  output logic [`RV_XLEN-1:0]           commit_wdata,
  output logic [`RV_XLEN-1:0]           commit_dnpc,
  output logic                          halted,
  output logic [`RV_XLEN-1:0]           halt_code
);

  logic                   ex_ebreak;
  logic [`RV_XLEN-1:0]    ex_a0;
  logic [`RV_XLEN-1:0]    dmem_addr;
  logic [`RV_XLEN-1:0]    dmem_wdata;
  logic [`RV_XLEN/8-1:0]  dmem_wmask;
  logic                   dmem_we;
  logic [`RV_XLEN-1:0]    dmem_rdata;

  rv_decode_if dec_if ();

  // stall on empty fetch, freeze after ebreak
  assign commit_valid = inst_valid && !halted;
  assign commit_rd    = dec_if.rd;

  rv_idu u_idu (
    .inst (inst),
    .dec  (dec_if.idu)
  );

  rv_exu u_exu (
    .clk        (clk),
    .arst_n     (arst_n),
    .commit_en  (commit_valid),
    .dec        (dec_if.exu),
    .pc         (pc),
    .wen        (commit_wen),
    .wdata      (commit_wdata),
    .dnpc       (commit_dnpc),
    .ebreak     (ex_ebreak),
    .a0         (ex_a0),
    .dmem_addr  (dmem_addr),
    .dmem_wdata (dmem_wdata),
    .dmem_wmask (dmem_wmask),
    .dmem_we    (dmem_we),
    .dmem_rdata (dmem_rdata)
  );

  rv_dmem u_dmem (
    .clk   (clk),
    .we    (dmem_we),
    .addr  (dmem_addr),
    .wdata (dmem_wdata),
    .wmask (dmem_wmask),
    .rdata (dmem_rdata)
  );

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc        <= `RV_RESET_PC;
      halted    <= 1'b0;
      halt_code <= '0;
    end else if (commit_valid) begin
      pc <= commit_dnpc;
      if (ex_ebreak) begin
        halted    <= 1'b1;
        halt_code <= ex_a0;
      end
    end
  end

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

  localparam int N_ENTRIES = 27;
  localparam int MAX_GAP   = 3;
  localparam int CLK_NS    = 40;
  localparam int WATCHDOG_CYCLES = 4 + N_ENTRIES * (1 + MAX_GAP) + 20 + 8;

  logic        clk;
  logic        arst_n;
  logic [31:0] inst;
  logic        inst_valid;
  logic [63:0] pc;
  logic        commit_valid;
  logic        commit_wen;
  logic [4:0]  commit_rd;
  logic [63:0] commit_wdata;
  logic [63:0] commit_dnpc;
  logic        halted;
  logic [63:0] halt_code;

  logic [31:0] t_inst  [N_ENTRIES];
  logic        t_wen   [N_ENTRIES];
  logic [4:0]  t_rd    [N_ENTRIES];
  logic [63:0] t_wdata [N_ENTRIES];
  logic [63:0] t_dnpc  [N_ENTRIES];
  int          t_test  [N_ENTRIES];

  int n_fill;
  int checks;
  int errors;
  int test_err;

  rv_core UUT (
    .clk          (clk),
    .arst_n       (arst_n),
    .inst         (inst),
    .inst_valid   (inst_valid),
    .pc           (pc),
    .commit_valid (commit_valid),
    .commit_wen   (commit_wen),
    .commit_rd    (commit_rd),
    .commit_wdata (commit_wdata),
    .commit_dnpc  (commit_dnpc),
    .halted       (halted),
    .halt_code    (halt_code)
  );

  always #(CLK_NS/2) clk = ~clk;

  // instruction encoders per RISC-V format
  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [4:0] rd, logic [6:0] opc);
    return {f7, rs2, rs1, 3'b000, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b011, imm[4:0], 7'b0100011};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1);
    return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic int unsigned lcg_next(int unsigned s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic add_entry(logic [31:0] i, logic w, logic [4:0] rd, logic [63:0] wd,
                           logic [63:0] np, int tn);
    t_inst[n_fill]  = i;
    t_wen[n_fill]   = w;
    t_rd[n_fill]    = rd;
    t_wdata[n_fill] = wd;
    t_dnpc[n_fill]  = np;
    t_test[n_fill]  = tn;
    n_fill++;
  endtask

  task automatic check_val(string name, logic [63:0] exp, logic [63:0] act);
    checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
      errors++;
      test_err++;
    end
  endtask

  task automatic report_test(int tn);
    if (test_err == 0) begin
      $display("test %0d: passed", tn);
    end else begin
      $display("test %0d: %0d mismatches", tn, test_err);
    end
    test_err = 0;
  endtask

  task automatic build_table();
    n_fill = 0;
    // arithmetic and x0
    add_entry(enc_i(12'd100, 5'd0, 3'b000, 5'd1, 7'b0010011), 1, 1, 64'd100, 64'd4, 1);
    add_entry(enc_i(12'hff9, 5'd0, 3'b000, 5'd2, 7'b0010011), 1, 2, -64'sd7, 64'd8, 1);
    add_entry(enc_r(7'h00, 5'd2, 5'd1, 5'd3, 7'b0110011), 1, 3, 64'd93, 64'd12, 1);
    add_entry(enc_r(7'h20, 5'd1, 5'd2, 5'd4, 7'b0110011), 1, 4, -64'sd107, 64'd16, 1);
    add_entry(enc_i(12'd5, 5'd1, 3'b000, 5'd0, 7'b0010011), 0, 0, 64'd0, 64'd20, 1);
    add_entry(enc_r(7'h00, 5'd1, 5'd0, 5'd5, 7'b0110011), 1, 5, 64'd100, 64'd24, 1);
    // upper immediates and word ops
    add_entry({20'h80000, 5'd6, 7'b0110111}, 1, 6, 64'hffff_ffff_8000_0000, 64'd28, 2);
    add_entry({20'h00001, 5'd7, 7'b0010111}, 1, 7, 64'h101c, 64'd32, 2);
    add_entry(enc_i(12'hfff, 5'd6, 3'b000, 5'd8, 7'b0011011), 1, 8, 64'h7fff_ffff,
              64'd36, 2);
    add_entry({20'h7ffff, 5'd9, 7'b0110111}, 1, 9, 64'h7fff_f000, 64'd40, 2);
    add_entry(enc_r(7'h00, 5'd9, 5'd9, 5'd10, 7'b0111011), 1, 10, 64'hffff_ffff_ffff_e000,
              64'd44, 2);
    // loads and stores
    add_entry(enc_i(12'd64, 5'd0, 3'b000, 5'd11, 7'b0010011), 1, 11, 64'd64, 64'd48, 3);
    add_entry(enc_s(12'd8, 5'd4, 5'd11), 0, 0, 64'd0, 64'd52, 3);
    add_entry(enc_i(12'd8, 5'd11, 3'b011, 5'd12, 7'b0000011), 1, 12, -64'sd107, 64'd56, 3);
    add_entry(enc_r(7'h00, 5'd8, 5'd8, 5'd13, 7'b0110011), 1, 13, 64'hffff_fffe,
              64'd60, 3);
    add_entry(enc_s(12'd16, 5'd13, 5'd11), 0, 0, 64'd0, 64'd64, 3);
    add_entry(enc_i(12'd16, 5'd11, 3'b010, 5'd14, 7'b0000011), 1, 14, -64'sd2, 64'd68, 3);
    add_entry(enc_i(12'd20, 5'd11, 3'b010, 5'd15, 7'b0000011), 1, 15, 64'd0, 64'd72, 3);
    add_entry(enc_i(12'd12, 5'd11, 3'b010, 5'd16, 7'b0000011), 1, 16, -64'sd1, 64'd76, 3);
    // jumps and branches
    add_entry(enc_j(21'd16, 5'd17), 1, 17, 64'd80, 64'd92, 4);
    add_entry(enc_i(12'd45, 5'd11, 3'b000, 5'd18, 7'b1100111), 1, 18, 64'd96, 64'd108, 4);
    add_entry(enc_b(13'd12, 5'd2, 5'd1), 0, 0, 64'd0, 64'd120, 4);
    add_entry(enc_b(13'd12, 5'd5, 5'd1), 0, 0, 64'd0, 64'd124, 4);
    // registers must have survived the stall gaps
    add_entry(enc_r(7'h00, 5'd12, 5'd3, 5'd19, 7'b0110011), 1, 19, -64'sd14, 64'd128, 5);
    add_entry(enc_r(7'h00, 5'd14, 5'd13, 5'd20, 7'b0110011), 1, 20, 64'hffff_fffc,
              64'd132, 5);
    // halt
    add_entry(enc_i(12'd42, 5'd0, 3'b000, 5'd10, 7'b0010011), 1, 10, 64'd42, 64'd136, 6);
    add_entry(32'h0010_0073, 0, 0, 64'd0, 64'd140, 6);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("timeout: the core did not reach the end of the table in time");
    $display("Test FAILED");
    $finish;
  end

  initial begin
    int unsigned seed;
    int          gap;
    logic [63:0] exp_pc;

    clk        = 1'b0;
    arst_n     = 1'b0;
    inst       = 32'h0000_0013;
    inst_valid = 1'b0;
    checks     = 0;
    errors     = 0;
    test_err   = 0;
    seed       = 53;
    exp_pc     = 64'd0;
    build_table();

    repeat (4) @(posedge clk);
    arst_n <= 1'b1;

    for (int e = 0; e < N_ENTRIES; e++) begin
      seed = lcg_next(seed);
      gap  = int'((seed >> 16) % (MAX_GAP + 1));
      for (int g = 0; g < gap; g++) begin
        @(posedge clk);
        // addi x3, x3, 1 would corrupt x3 if a stalled cycle ever committed
        inst       <= enc_i(12'd1, 5'd3, 3'b000, 5'd3, 7'b0010011);
        inst_valid <= 1'b0;
        @(negedge clk);
        check_val("commit_valid", 64'd0, {63'd0, commit_valid});
        check_val("commit_wen", 64'd0, {63'd0, commit_wen});
        check_val("pc", exp_pc, pc);
      end
      @(posedge clk);
      inst       <= t_inst[e];
      inst_valid <= 1'b1;
      @(negedge clk);
      check_val("pc", exp_pc, pc);
      check_val("commit_valid", 64'd1, {63'd0, commit_valid});
      check_val("commit_wen", {63'd0, t_wen[e]}, {63'd0, commit_wen});
      if (t_wen[e]) begin
        check_val("commit_rd", {59'd0, t_rd[e]}, {59'd0, commit_rd});
        check_val("commit_wdata", t_wdata[e], commit_wdata);
      end
      check_val("commit_dnpc", t_dnpc[e], commit_dnpc);
      exp_pc = t_dnpc[e];
      if (e + 1 < N_ENTRIES && t_test[e + 1] != t_test[e]) begin
        report_test(t_test[e]);
      end
    end

    // halted core ignores further fetches
    for (int k = 0; k < 4; k++) begin
      @(posedge clk);
      inst       <= enc_i(12'd1, 5'd0, 3'b000, 5'd21, 7'b0010011);
      inst_valid <= 1'b1;
      @(negedge clk);
      check_val("halted", 64'd1, {63'd0, halted});
      check_val("halt_code", 64'd42, halt_code);
      check_val("commit_valid", 64'd0, {63'd0, commit_valid});
      check_val("commit_wen", 64'd0, {63'd0, commit_wen});
      check_val("pc", exp_pc, pc);
    end
    report_test(6);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

// ==== rv_core.f ====
+incdir+.
rv_pkg.sv
rv_decode_if.sv
rv_alu.sv
rv_regfile.sv
rv_dmem.sv
rv_idu.sv
rv_exu.sv
rv_core.sv
tb_rv_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Compile and run the rv_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f rv_core.f --top-module tb_rv_core -Mdir obj_dir
status=$?
if [ $status -ne 0 ]; then
  echo "compile failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_rv_core)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Test OK"; then
  exit 0
fi
exit 1
